//--- logic/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_RESET_VECTOR 32'h0000_0004  // First fetch address

// Primary opcodes
`define OP_SPECIAL 6'h00
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// Funct codes of SPECIAL instructions
`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_JR      6'h08
`define FN_MFHI    6'h10
`define FN_MFLO    6'h12
`define FN_MULT    6'h18
`define FN_MULTU   6'h19
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26

`define MUL_STEPS 32  // One iteration per multiplier bit

`endif

//--- logic/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;     // Data word or byte address
    typedef logic [4:0]  reg_idx_t;  // GPR number
    typedef logic [5:0]  opcode_t;   // Opcode or funct field

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [3:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_MEM_WAIT,
        ST_MUL_WAIT,
        ST_WRITEBACK,
        ST_HALTED
    } core_state_t;

    typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_FIX_SIGN} mul_state_t;

endpackage

//--- logic/muldiv_if.sv
`timescale 1ns/1ps

interface muldiv_if;

    logic            start;      // One-cycle request from the core
    logic            is_signed;  // mult rather than multu
    mips_pkg::word_t op_a;
    mips_pkg::word_t op_b;
    logic            busy;
    mips_pkg::word_t hi;
    mips_pkg::word_t lo;

    modport core (
        output start, is_signed, op_a, op_b,
        input  busy, hi, lo
    );

    modport unit (
        input  start, is_signed, op_a, op_b,
        output busy, hi, lo
    );

endinterface

//--- logic/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t wr_idx,
    input  logic               wr_en,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    rs_val,
    output mips_pkg::word_t    rt_val,
    output mips_pkg::word_t    v0
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin  // $zero stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    // Plain combinational reads since the core never reads in its write cycle
    assign rs_val = (rs_idx == 5'd0) ? '0 : regs[rs_idx];
    assign rt_val = (rt_idx == 5'd0) ? '0 : regs[rt_idx];

    assign v0 = regs[2];  // Debug view of $v0

endmodule

//--- logic/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   y
);

    // Immediates arrive already extended in b
    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                y = a + b;  // addu, addiu and address calculation
            end
            mips_pkg::ALU_SUB: begin
                y = a - b;
            end
            mips_pkg::ALU_AND: begin
                y = a & b;
            end
            mips_pkg::ALU_OR: begin
                y = a | b;  // Also ori with zero-extended b
            end
            mips_pkg::ALU_XOR: begin
                y = a ^ b;
            end
            mips_pkg::ALU_SLL: begin
                y = b << shamt;  // Shifts act on rt
            end
            mips_pkg::ALU_SRL: begin
                y = b >> shamt;  // Logical so zeros shift in
            end
            mips_pkg::ALU_LUI: begin
                y = {b[15:0], 16'h0000};
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- logic/mips_muldiv.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_muldiv (
    input  logic   clk,
    input  logic   reset,
    muldiv_if.unit mul
);

    localparam int STEP_W = $clog2(`MUL_STEPS);

    mips_pkg::mul_state_t state;
    logic [STEP_W-1:0]    step;
    logic [63:0]          acc;     // Running sum of partial products
    logic [63:0]          mcand;   // Shifted multiplicand magnitude
    mips_pkg::word_t      mplier;  // Multiplier magnitude, consumed LSB first
    logic                 negate;
    mips_pkg::word_t      mag_a;
    mips_pkg::word_t      mag_b;

    assign mag_a = (mul.is_signed && mul.op_a[31]) ? -mul.op_a : mul.op_a;
    assign mag_b = (mul.is_signed && mul.op_b[31]) ? -mul.op_b : mul.op_b;

    assign mul.busy = (state != mips_pkg::MUL_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= mips_pkg::MUL_IDLE;
            step   <= '0;
            mul.hi <= '0;
            mul.lo <= '0;
        end else begin
            case (state)
                mips_pkg::MUL_IDLE: begin
                    if (mul.start) begin
                        acc    <= '0;
                        mcand  <= {32'h0, mag_a};
                        mplier <= mag_b;
                        negate <= mul.is_signed && (mul.op_a[31] ^ mul.op_b[31]);
                        step   <= '0;
                        state  <= mips_pkg::MUL_RUN;
                    end
                end
                mips_pkg::MUL_RUN: begin
                    if (mplier[0]) begin
                        acc <= acc + mcand;
                    end
                    mcand  <= mcand << 1;
                    mplier <= mplier >> 1;
                    step   <= step + 1'b1;
                    if (step == STEP_W'(`MUL_STEPS - 1)) begin
                        state <= mips_pkg::MUL_FIX_SIGN;
                    end
                end
                mips_pkg::MUL_FIX_SIGN: begin
                    {mul.hi, mul.lo} <= negate ? -acc : acc;  // Unsigned passes through
                    state            <= mips_pkg::MUL_IDLE;
                end
                default: begin
                    state <= mips_pkg::MUL_IDLE;
                end
            endcase
        end
    end

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        mul.start |-> !mul.busy)
        else $error("multiply started while busy");

endmodule

//--- logic/mips_core.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core (
    input  logic               clk,
    input  logic               reset,
    output mips_pkg::word_t    address,
    output logic               write,
    output logic               read,
    output mips_pkg::word_t    writedata,
    output logic [3:0]         byteenable,
    input  mips_pkg::word_t    readdata,
    input  logic               waitrequest,
    output logic               active,
    output mips_pkg::reg_idx_t rs_idx,
    output mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::word_t    rs_val,
    input  mips_pkg::word_t    rt_val,
    output logic               wr_en,
    output mips_pkg::reg_idx_t wr_idx,
    output mips_pkg::word_t    wr_data,
    output mips_pkg::alu_op_t  alu_op,
    output mips_pkg::word_t    alu_a,
    output mips_pkg::word_t    alu_b,
    output logic [4:0]         shamt,
    input  mips_pkg::word_t    alu_y,
    muldiv_if.core             mul
);

    mips_pkg::core_state_t state;
    mips_pkg::word_t       pc;
    mips_pkg::word_t       ir;
    mips_pkg::word_t       a_reg;        // rs latched in decode
    mips_pkg::word_t       b_reg;        // rt latched in decode
    mips_pkg::word_t       result;
    mips_pkg::word_t       jump_target;
    logic                  jump_pending;  // Next writeback is the delay slot
    logic                  halt_req;      // Pending jump goes to address zero
    mips_pkg::opcode_t     opcode;
    mips_pkg::opcode_t     funct;
    mips_pkg::word_t       imm_ext;
    logic                  is_special;
    logic                  is_jr;
    logic                  is_mult;
    logic                  is_mfhilo;
    logic                  is_lw;
    logic                  is_sw;
    logic                  writes_reg;

    assign opcode     = ir[31:26];
    assign funct      = ir[5:0];
    assign is_special = (opcode == `OP_SPECIAL);
    assign is_jr      = is_special && (funct == `FN_JR);
    assign is_mult    = is_special && ((funct == `FN_MULT) || (funct == `FN_MULTU));
    assign is_mfhilo  = is_special && ((funct == `FN_MFHI) || (funct == `FN_MFLO));
    assign is_lw      = (opcode == `OP_LW);
    assign is_sw      = (opcode == `OP_SW);
    assign imm_ext    = (opcode == `OP_ORI) ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

    assign rs_idx     = ir[25:21];
    assign rt_idx     = ir[20:16];
    assign wr_idx     = is_special ? ir[15:11] : ir[20:16];  // rd for R-type, rt otherwise
    assign wr_en      = (state == mips_pkg::ST_WRITEBACK) && writes_reg;
    assign wr_data    = result;
    assign alu_a      = a_reg;
    assign alu_b      = is_special ? b_reg : imm_ext;
    assign shamt      = ir[10:6];
    assign byteenable = 4'b1111;  // Whole words only

    assign mul.start     = (state == mips_pkg::ST_MUL_WAIT) && is_mult && !mul.busy;
    assign mul.is_signed = (funct == `FN_MULT);
    assign mul.op_a      = a_reg;
    assign mul.op_b      = b_reg;

    // ALU operation and destination write enable
    always_comb begin
        alu_op     = mips_pkg::ALU_ADD;
        writes_reg = 1'b0;
        if (is_special) begin
            case (funct)
                `FN_SLL:                     {alu_op, writes_reg} = {mips_pkg::ALU_SLL, 1'b1};
                `FN_SRL:                     {alu_op, writes_reg} = {mips_pkg::ALU_SRL, 1'b1};
                `FN_SUBU:                    {alu_op, writes_reg} = {mips_pkg::ALU_SUB, 1'b1};
                `FN_AND:                     {alu_op, writes_reg} = {mips_pkg::ALU_AND, 1'b1};
                `FN_OR:                      {alu_op, writes_reg} = {mips_pkg::ALU_OR, 1'b1};
                `FN_XOR:                     {alu_op, writes_reg} = {mips_pkg::ALU_XOR, 1'b1};
                `FN_ADDU, `FN_MFHI, `FN_MFLO: writes_reg = 1'b1;
                default:                     writes_reg = 1'b0;  // jr, mult, multu
            endcase
        end else begin
            case (opcode)
                `OP_ADDIU, `OP_LW: writes_reg = 1'b1;
                `OP_ORI:           {alu_op, writes_reg} = {mips_pkg::ALU_OR, 1'b1};
                `OP_LUI:           {alu_op, writes_reg} = {mips_pkg::ALU_LUI, 1'b1};
                default:           writes_reg = 1'b0;  // sw only computes an address
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= mips_pkg::ST_FETCH;
            pc           <= `MIPS_RESET_VECTOR;
            address      <= '0;
            writedata    <= '0;
            read         <= 1'b0;
            write        <= 1'b0;
            active       <= 1'b0;
            jump_pending <= 1'b0;
            halt_req     <= 1'b0;
        end else begin
            case (state)
                mips_pkg::ST_FETCH: begin
                    address <= pc;
                    read    <= 1'b1;
                    active  <= 1'b1;
                    state   <= mips_pkg::ST_FETCH_WAIT;
                end
                mips_pkg::ST_FETCH_WAIT: begin
                    if (!waitrequest) begin  // Zero read latency
                        ir    <= readdata;
                        read  <= 1'b0;
                        pc    <= pc + 32'd4;
                        state <= mips_pkg::ST_DECODE;
                    end
                end
                mips_pkg::ST_DECODE: begin
                    a_reg <= rs_val;
                    b_reg <= rt_val;
                    state <= mips_pkg::ST_EXECUTE;
                end
                mips_pkg::ST_EXECUTE: begin
                    result <= alu_y;
                    if (is_jr) begin
                        jump_target <= a_reg;
                        halt_req    <= (a_reg == '0);
                    end
                    if (is_lw || is_sw) begin
                        state <= mips_pkg::ST_MEM;
                    end else if (is_mult || is_mfhilo) begin
                        state <= mips_pkg::ST_MUL_WAIT;
                    end else begin
                        state <= mips_pkg::ST_WRITEBACK;
                    end
                end
                mips_pkg::ST_MEM: begin
                    address   <= result;
                    writedata <= b_reg;
                    read      <= is_lw;
                    write     <= is_sw;
                    state     <= mips_pkg::ST_MEM_WAIT;
                end
                mips_pkg::ST_MEM_WAIT: begin
                    if (!waitrequest) begin
                        if (is_lw) begin
                            result <= readdata;
                        end
                        read  <= 1'b0;
                        write <= 1'b0;
                        state <= mips_pkg::ST_WRITEBACK;
                    end
                end
                mips_pkg::ST_MUL_WAIT: begin
                    if (!mul.busy) begin  // mult launches here, mfhi and mflo read
                        result <= (funct == `FN_MFHI) ? mul.hi : mul.lo;
                        state  <= mips_pkg::ST_WRITEBACK;
                    end
                end
                mips_pkg::ST_WRITEBACK: begin
                    if (jump_pending) begin  // Delay slot has just retired
                        jump_pending <= 1'b0;
                        pc           <= jump_target;
                    end else if (is_jr) begin
                        jump_pending <= 1'b1;
                    end
                    if (jump_pending && halt_req) begin
                        active <= 1'b0;
                        state  <= mips_pkg::ST_HALTED;
                    end else begin
                        state <= mips_pkg::ST_FETCH;
                    end
                end
                mips_pkg::ST_HALTED: begin
                    active <= 1'b0;  // Held until reset
                end
                default: begin
                    state <= mips_pkg::ST_FETCH;
                end
            endcase
        end
    end

    a_no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write high together");

    a_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable({address, writedata, read, write, byteenable}))
        else $error("bus outputs changed during waitrequest");

endmodule

//--- logic/mips_cpu.sv
`timescale 1ns/1ps

module mips_cpu (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata,
    input  logic            waitrequest
);

    mips_pkg::reg_idx_t rs_idx;
    mips_pkg::reg_idx_t rt_idx;
    mips_pkg::reg_idx_t wr_idx;
    mips_pkg::word_t    rs_val;
    mips_pkg::word_t    rt_val;
    mips_pkg::word_t    wr_data;
    logic               wr_en;
    mips_pkg::alu_op_t  alu_op;
    mips_pkg::word_t    alu_a;
    mips_pkg::word_t    alu_b;
    mips_pkg::word_t    alu_y;
    logic [4:0]         shamt;

    muldiv_if u_mul_if ();

    mips_core u_core (
        .clk(clk), .reset(reset),
        .address(address), .write(write), .read(read), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest),
        .active(active),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_val(rs_val), .rt_val(rt_val),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .shamt(shamt), .alu_y(alu_y),
        .mul(u_mul_if)
    );

    mips_regfile u_regfile (
        .clk(clk), .reset(reset),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .wr_idx(wr_idx),
        .wr_en(wr_en), .wr_data(wr_data),
        .rs_val(rs_val), .rt_val(rt_val),
        .v0(register_v0)  // $v0 for the testbench
    );

    mips_alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .shamt(shamt), .y(alu_y));

    mips_muldiv u_muldiv (.clk(clk), .reset(reset), .mul(u_mul_if));

endmodule

//--- dv/avalon_mem_model.sv
`timescale 1ns/1ps

module avalon_mem_model (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic        stall,      // Back-pressure request from the testbench
    input  logic        load_en,
    input  logic [8:0]  load_addr,  // Word index
    input  logic [31:0] load_data
);

    logic [31:0] mem [512];

    assign waitrequest = (read || write) && stall;
    assign readdata    = mem[address[10:2]];  // Zero read latency

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (write && !waitrequest && (byteenable == 4'hf)) begin
            mem[address[10:2]] <= writedata;
        end
    end

endmodule

//--- dv/mips_cpu_tb.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_cpu_tb;

    localparam int PROG_LEN  = 42;
    localparam int WIN       = 16;
    localparam int WIN_WORD  = 256;       // Data window at byte 0x400
    localparam int NUM_PROGS = 3;
    localparam int TIMEOUT   = 20000;

    logic clk = 1'b0;
    logic reset, active, write, read, waitrequest, stall, load_en, waits_on;
    logic [31:0] register_v0, address, writedata, readdata, load_data, seed;
    logic [3:0]  byteenable;
    logic [8:0]  load_addr;
    logic [31:0] prog [PROG_LEN];
    logic [31:0] win [WIN];
    logic [31:0] m_win [WIN];             // Model data window
    logic [31:0] m_regs [32];
    logic [31:0] m_hi, m_lo, held_addr, held_wd;
    logic [1:0]  held_rw;
    logic        was_stalled = 1'b0;

    always #2 clk = ~clk;

    mips_cpu u_mips_cpu (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest)
    );

    avalon_mem_model u_mem (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .waitrequest(waitrequest), .stall(stall),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return 5'd2 + {2'b00, r[2:0]};   // $v0 to $t1
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // Builds a straight-line program and runs it on the ISA model at once
    task automatic make_program();
        logic [31:0] r, a, b;
        logic [4:0]  rs, rt, rd, sh;
        logic [15:0] imm, off;
        logic [63:0] p;
        int          sel;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        m_hi = '0;
        m_lo = '0;
        for (int i = 0; i < WIN; i++) begin
            win[i]   = next_rand();
            m_win[i] = win[i];
        end
        for (int n = 0; n < PROG_LEN - 2; n++) begin
            r   = next_rand();
            rs  = pick_reg();
            rt  = pick_reg();
            rd  = pick_reg();
            imm = r[31:16];
            sh  = r[10:6];
            off = 16'h0400 + {10'd0, r[19:16], 2'b00};
            a   = m_regs[rs];
            b   = m_regs[rt];
            sel = int'(r[3:0]) % 11;
            case (sel)
                0: begin
                    prog[n]    = {`OP_ADDIU, rs, rt, imm};
                    m_regs[rt] = a + {{16{imm[15]}}, imm};
                end
                1: begin
                    prog[n]    = {`OP_ORI, rs, rt, imm};
                    m_regs[rt] = a | {16'h0000, imm};
                end
                2: begin
                    prog[n]    = {`OP_LUI, 5'd0, rt, imm};
                    m_regs[rt] = {imm, 16'h0000};
                end
                3: begin
                    prog[n]    = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_ADDU};
                    m_regs[rd] = a + b;
                end
                4: begin
                    prog[n]    = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_SUBU};
                    m_regs[rd] = a - b;
                end
                5: begin
                    prog[n]    = {`OP_SPECIAL, rs, rt, rd, 5'd0,
                                  r[4] ? `FN_AND : (r[5] ? `FN_OR : `FN_XOR)};
                    m_regs[rd] = r[4] ? (a & b) : (r[5] ? (a | b) : (a ^ b));
                end
                6: begin
                    prog[n]    = {`OP_SPECIAL, 5'd0, rt, rd, sh, r[4] ? `FN_SLL : `FN_SRL};
                    m_regs[rd] = r[4] ? (b << sh) : (b >> sh);
                end
                7: begin
                    prog[n]    = {`OP_LW, 5'd0, rt, off};
                    m_regs[rt] = m_win[r[19:16]];
                end
                8: begin
                    prog[n]         = {`OP_SW, 5'd0, rt, off};
                    m_win[r[19:16]] = b;
                end
                9: begin
                    prog[n] = {`OP_SPECIAL, rs, rt, 10'd0, r[4] ? `FN_MULT : `FN_MULTU};
                    if (r[4]) p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    else p = {32'd0, a} * {32'd0, b};
                    {m_hi, m_lo} = p;
                end
                default: begin
                    prog[n]    = {`OP_SPECIAL, 10'd0, rd, 5'd0, r[4] ? `FN_MFHI : `FN_MFLO};
                    m_regs[rd] = r[4] ? m_hi : m_lo;
                end
            endcase
        end
        r = next_rand();
        prog[PROG_LEN-2] = {`OP_SPECIAL, 5'd0, 15'd0, `FN_JR};      // jr $zero
        prog[PROG_LEN-1] = {`OP_ADDIU, 5'd2, 5'd2, r[15:0]};        // Delay slot
        m_regs[2] = m_regs[2] + {{16{r[15]}}, r[15:0]};
    endtask

    task automatic load_memory();
        for (int i = 0; i < PROG_LEN + WIN; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = (i < PROG_LEN) ? 9'((`MIPS_RESET_VECTOR >> 2) + i)
                                       : 9'(WIN_WORD + i - PROG_LEN);
            load_data = (i < PROG_LEN) ? prog[i] : win[i - PROG_LEN];
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_program(input logic with_waits);
        int cyc;
        waits_on = 1'b0;
        load_memory();
        reset    = 1'b1;
        repeat (4) @(negedge clk);
        check("active in reset", {31'd0, active}, 32'd0);
        check("read/write in reset", {30'd0, read, write}, 32'd0);
        waits_on = with_waits;
        reset    = 1'b0;
        @(negedge clk);
        check("active after reset", {31'd0, active}, 32'd1);
        check("first fetch read", {31'd0, read}, 32'd1);
        check("first fetch address", address, `MIPS_RESET_VECTOR);
        cyc = 0;
        while (active && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (active) begin
            $display("Timeout: the CPU never halted");
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
        check("register_v0", register_v0, m_regs[2]);
        for (int i = 0; i < WIN; i++) begin
            check("data window word", u_mem.mem[WIN_WORD + i], m_win[i]);
        end
        repeat (8) @(negedge clk);
        check("active after halt", {31'd0, active}, 32'd0);
    endtask

    // Random back-pressure only while a run is in progress
    always @(negedge clk) begin
        if (waits_on && active) stall = next_rand() > 32'h8000_0000;
        else stall = 1'b0;
    end

    // Bus must hold through any stalled cycle
    always @(posedge clk) begin
        if (!reset && was_stalled) begin
            check("address during stall", address, held_addr);
            check("writedata during stall", writedata, held_wd);
            check("read/write during stall", {30'd0, read, write}, {30'd0, held_rw});
        end
        if (!reset && (read || write)) begin
            check("byteenable", {28'd0, byteenable}, 32'h0000_000f);  // Whole words only
        end
        was_stalled = !reset && (read || write) && waitrequest;
        held_addr   = address;
        held_wd     = writedata;
        held_rw     = {read, write};
    end

    initial begin
        reset     = 1'b1;
        stall     = 1'b0;
        waits_on  = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed      = 32'hba145d5e;
        for (int n = 0; n < NUM_PROGS; n++) begin
            make_program();
            run_program(1'b0);
            run_program(1'b1);  // Same program again under random waitrequest
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+logic
logic/mips_pkg.sv
logic/muldiv_if.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_muldiv.sv
logic/mips_core.sv
logic/mips_cpu.sv
dv/avalon_mem_model.sv
dv/mips_cpu_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mips_cpu_tb
FILELIST = list.f

BIN  = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) logic/mips_defs.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
